/* verilog/sha2_pkg.sv */
// SHA-224 and SHA-256 only; hash words are packed H0 first, i.e. H0 sits in the top 32 bits
`default_nettype none

package sha2_pkg;

    typedef enum logic [0:0] {
        SHA224 = 1'b0,
        SHA256 = 1'b1
    } sha2_mode_t;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD  = 3'd1,
        ROUND = 3'd2,
        ADD   = 3'd3,
        OUT   = 3'd4
    } sha2_state_t;

    localparam int num_rounds      = 64;
    localparam int words_per_block = 8; // 64-bit words per 512-bit block

    // K[0..63], first cube-root fractions of the first 64 primes
    localparam logic [0:63][31:0] round_k = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
        32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
        32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
        32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
        32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
        32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    localparam logic [0:7][31:0] iv_224 = '{
        32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
        32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
    };

    localparam logic [0:7][31:0] iv_256 = '{
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

endpackage

`default_nettype wire

/* verilog/mmio_pkg.sv */
// register map of a 32-bit bus, word index taken from address bits 4:2
`default_nettype none

package mmio_pkg;

    typedef enum logic [2:0] {
        CTRL_0    = 3'd0,
        CTRL_1    = 3'd1,
        DATA_I_LO = 3'd2,
        DATA_I_HI = 3'd3,
        DATA_O_LO = 3'd4,
        DATA_O_HI = 3'd5,
        RSVD_0    = 3'd6,
        RSVD_1    = 3'd7
    } reg_idx_t;

    localparam int ctrl0_rst_bit       = 0; // core enable, active high
    localparam int ctrl0_intr_next_bit = 30;
    localparam int ctrl0_intr_done_bit = 31;

    localparam int ctrl1_last_bit = 0;
    localparam int ctrl1_mode_lsb = 1; // two bits, 0 selects SHA-224
    localparam int ctrl1_next_bit = 30;
    localparam int ctrl1_done_bit = 31;

endpackage

`default_nettype wire

/* verilog/sha2_msg_sched.sv */
// each 64-bit input word holds two message words, high half first; clear before the next block
`timescale 1ns/10ps
`default_nettype none

module sha2_msg_sched (
    input  wire         clk_i,
    input  wire         rst_n_i,
    input  wire  [63:0] in_data_i,
    input  wire         in_valid_i,
    input  wire         shift_i,
    input  wire         clear_i,
    output logic        in_ready_o,
    output logic        blk_full_o,
    output logic [31:0] w_o
);

    localparam int cnt_w = $clog2(sha2_pkg::words_per_block) + 1;

    logic [31:0]      win [0:15]; // win[0] is the oldest word
    logic [cnt_w-1:0] cnt;
    logic [31:0]      w_next;
    logic             take;

    function automatic logic [31:0] sigma0(input logic [31:0] x);
        sigma0 = {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
    endfunction

    function automatic logic [31:0] sigma1(input logic [31:0] x);
        sigma1 = {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
    endfunction

    assign take       = in_valid_i & in_ready_o;
    assign in_ready_o = (cnt != cnt_w'(sha2_pkg::words_per_block));
    assign blk_full_o = take & (cnt == cnt_w'(sha2_pkg::words_per_block - 1)); // eighth word now
    assign w_o        = win[0];

    // W[t+16] from the window
    assign w_next = sigma1(win[14]) + win[9] + sigma0(win[1]) + win[0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt <= '0;
        end else if (clear_i) begin
            cnt <= '0;
        end else if (take) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            for (int i = 0; i < 14; i++) begin
                win[i] <= win[i+2];
            end
            win[14] <= in_data_i[63:32];
            win[15] <= in_data_i[31:0];
        end else if (shift_i) begin
            for (int i = 0; i < 15; i++) begin
                win[i] <= win[i+1];
            end
            win[15] <= w_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/sha2_round.sv */
// one compression round per step; w_i must be the schedule word of round_i in the same cycle
`timescale 1ns/10ps
`default_nettype none

module sha2_round (
    input  wire                                    clk_i,
    input  wire                                    rst_n_i,
    input  wire                                    load_i,
    input  wire                                    step_i,
    input  wire [$clog2(sha2_pkg::num_rounds)-1:0] round_i,
    input  wire [31:0]                             w_i,
    input  wire [255:0]                            h_i,
    output logic [255:0]                           work_o
);

    logic [31:0] a, b, c, d, e, f, g, h;
    logic [31:0] ch;
    logic [31:0] maj;
    logic [31:0] t1;
    logic [31:0] t2;

    function automatic logic [31:0] big_sigma0(input logic [31:0] x);
        big_sigma0 = {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
    endfunction

    function automatic logic [31:0] big_sigma1(input logic [31:0] x);
        big_sigma1 = {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
    endfunction

    assign ch  = (e & f) ^ (~e & g);      // e picks f or g
    assign maj = (a & b) ^ (a & c) ^ (b & c);

    assign t1 = h + big_sigma1(e) + ch + sha2_pkg::round_k[round_i] + w_i;
    assign t2 = big_sigma0(a) + maj;

    assign work_o = {a, b, c, d, e, f, g, h};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {a, b, c, d, e, f, g, h} <= '0;
        end else if (load_i) begin
            {a, b, c, d, e, f, g, h} <= h_i; // start from the current hash state
        end else if (step_i) begin
            a <= t1 + t2;
            b <= a;
            c <= b;
            d <= c;
            e <= d + t1;
            f <= e;
            g <= f;
            h <= g;
        end
    end

endmodule

`default_nettype wire

/* verilog/sha2_digest.sv */
// four 64-bit output words, H0:H1 first; for SHA-224 the low half of the last word reads zero
`timescale 1ns/10ps
`default_nettype none

module sha2_digest (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire sha2_pkg::sha2_mode_t mode_i,
    input  wire                       init_i,
    input  wire                       add_i,
    input  wire [255:0]               work_i,
    input  wire                       out_ready_i,
    input  wire                       out_en_i,
    output logic [255:0]              h_o,
    output logic [63:0]               out_data_o,
    output logic                      out_valid_o,
    output logic                      out_empty_o
);

    logic [0:7][31:0] hs;
    logic [0:7][31:0] work;
    logic [0:7][31:0] iv;
    logic [1:0]       ptr;   // output word, 0..3
    logic [31:0]      lo_word;

    assign work = work_i;
    assign iv   = (mode_i == sha2_pkg::SHA224) ? sha2_pkg::iv_224 : sha2_pkg::iv_256;

    // IV shows through while it is being loaded, so the rounds can start from it
    assign h_o = init_i ? iv : hs;

    assign lo_word     = (mode_i == sha2_pkg::SHA224 && ptr == 2'd3) ? 32'h0 : hs[{ptr, 1'b1}];
    assign out_data_o  = {hs[{ptr, 1'b0}], lo_word};
    assign out_valid_o = out_en_i & ~out_empty_o;

    always_ff @(posedge clk_i) begin
        if (init_i) begin
            hs <= iv;
        end else if (add_i) begin
            for (int i = 0; i < 8; i++) begin
                hs[i] <= hs[i] + work[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr         <= '0;
            out_empty_o <= 1'b0;
        end else if (init_i) begin
            ptr         <= '0;
            out_empty_o <= 1'b0;
        end else if (out_valid_o && out_ready_i) begin
            ptr <= ptr + 1'b1; // wraps back to 0 after the fourth word
            if (ptr == 2'd3) begin
                out_empty_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sha2.sv */
// whole 512-bit blocks only; last and mode are sampled as each block starts, 66 cycles per block
`timescale 1ns/10ps
`default_nettype none

module sha2 (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire sha2_pkg::sha2_mode_t mode_i,
    input  wire                       last_i,
    input  wire [63:0]                in_data_i,
    input  wire                       in_valid_i,
    output logic                      in_ready_o,
    output logic [63:0]               out_data_o,
    output logic                      out_valid_o,
    input  wire                       out_ready_i,
    output logic                      next_o,
    output logic                      done_o
);

    localparam int rnd_w = $clog2(sha2_pkg::num_rounds);

    sha2_pkg::sha2_state_t state;
    sha2_pkg::sha2_mode_t  mode_q;
    sha2_pkg::sha2_mode_t  dig_mode;

    logic [rnd_w-1:0] round;
    logic             last_q;
    logic             msg_first; // next block begins a new message
    logic             idle;
    logic             sched_ready;
    logic             blk_full;
    logic             out_empty;
    logic             dig_init;
    logic [31:0]      w;
    logic [255:0]     h;
    logic [255:0]     work;

    assign idle       = (state == sha2_pkg::IDLE);
    assign in_ready_o = sched_ready & idle;
    assign next_o     = idle & ~msg_first;
    assign done_o     = (state == sha2_pkg::OUT) & ~out_empty;

    // first block takes the IV of the mode written for it, not of the previous message
    assign dig_mode = (state == sha2_pkg::LOAD) ? mode_i : mode_q;
    assign dig_init = ((state == sha2_pkg::LOAD) & msg_first)
                    | ((state == sha2_pkg::OUT) & out_empty);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= sha2_pkg::IDLE;
            round     <= '0;
            last_q    <= 1'b0;
            mode_q    <= sha2_pkg::SHA224;
            msg_first <= 1'b1;
        end else begin
            case (state)
                sha2_pkg::IDLE: if (blk_full) state <= sha2_pkg::LOAD;
                sha2_pkg::LOAD: begin
                    state     <= sha2_pkg::ROUND;
                    round     <= '0;
                    last_q    <= last_i;
                    mode_q    <= mode_i;
                    msg_first <= 1'b0;
                end
                sha2_pkg::ROUND: begin
                    round <= round + 1'b1;
                    if (round == rnd_w'(sha2_pkg::num_rounds - 1)) state <= sha2_pkg::ADD;
                end
                sha2_pkg::ADD: state <= last_q ? sha2_pkg::OUT : sha2_pkg::IDLE;
                sha2_pkg::OUT: begin
                    if (out_empty) begin
                        state     <= sha2_pkg::IDLE;
                        msg_first <= 1'b1;
                    end
                end
                default: state <= sha2_pkg::IDLE;
            endcase
        end
    end

    sha2_msg_sched i_sched (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_data_i  (in_data_i),
        .in_valid_i (in_valid_i & idle),
        .shift_i    (state == sha2_pkg::ROUND),
        .clear_i    (state == sha2_pkg::ADD),
        .in_ready_o (sched_ready),
        .blk_full_o (blk_full),
        .w_o        (w)
    );

    sha2_round i_round (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (state == sha2_pkg::LOAD),
        .step_i  (state == sha2_pkg::ROUND),
        .round_i (round),
        .w_i     (w),
        .h_i     (h),
        .work_o  (work)
    );

    sha2_digest i_digest (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mode_i      (dig_mode),
        .init_i      (dig_init),
        .add_i       (state == sha2_pkg::ADD),
        .work_i      (work),
        .out_ready_i (out_ready_i),
        .out_en_i    (state == sha2_pkg::OUT),
        .h_o         (h),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_empty_o (out_empty)
    );

endmodule

`default_nettype wire

/* verilog/mmio_sha2.sv */
// software pads messages to whole blocks; one DATA_I_HI write per accepted word, addr_width >= 5
`timescale 1ns/10ps
`default_nettype none

module mmio_sha2 #(
    parameter int addr_width = 8
) (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire                  wr_en_i,
    input  wire [addr_width-1:0] wr_addr_i,
    input  wire [31:0]           wr_data_i,
    input  wire                  rd_en_i,
    input  wire [addr_width-1:0] rd_addr_i,
    output logic [31:0]          rd_data_o,
    output logic                 intr_o
);

    mmio_pkg::reg_idx_t   wr_idx;
    mmio_pkg::reg_idx_t   rd_idx;
    sha2_pkg::sha2_mode_t core_mode;

    logic        soft_rst_n;
    logic        core_rst_n;
    logic        last;
    logic [1:0]  mode;
    logic        intr_next;
    logic        intr_done;
    logic [31:0] stage_lo;
    logic [31:0] stage_hi;
    logic [63:0] in_data;
    logic        in_valid;
    logic        in_ready;
    logic [63:0] out_data;
    logic        out_valid;
    logic        out_ready;
    logic        core_next;
    logic        core_done;
    logic        next_d;
    logic        done_d;
    logic        ctrl0_rd;
    logic [31:0] rd_mux;

    assign wr_idx = mmio_pkg::reg_idx_t'(wr_addr_i[4:2]);
    assign rd_idx = mmio_pkg::reg_idx_t'(rd_addr_i[4:2]);

    assign core_rst_n = rst_n_i & soft_rst_n; // core stays idle until CTRL_0 bit 0 is set
    assign core_mode  = (mode == 2'b00) ? sha2_pkg::SHA224 : sha2_pkg::SHA256;
    assign ctrl0_rd   = rd_en_i & (rd_idx == mmio_pkg::CTRL_0);
    assign intr_o     = intr_next | intr_done;

    always_comb begin
        rd_mux = '0;
        case (rd_idx)
            mmio_pkg::CTRL_0: begin
                rd_mux[mmio_pkg::ctrl0_rst_bit]       = soft_rst_n;
                rd_mux[mmio_pkg::ctrl0_intr_next_bit] = intr_next;
                rd_mux[mmio_pkg::ctrl0_intr_done_bit] = intr_done;
            end
            mmio_pkg::CTRL_1: begin
                rd_mux[mmio_pkg::ctrl1_last_bit]      = last;
                rd_mux[mmio_pkg::ctrl1_mode_lsb +: 2] = mode;
                rd_mux[mmio_pkg::ctrl1_next_bit]      = core_next; // live status
                rd_mux[mmio_pkg::ctrl1_done_bit]      = core_done;
            end
            mmio_pkg::DATA_I_LO: rd_mux = stage_lo;
            mmio_pkg::DATA_I_HI: rd_mux = stage_hi;
            mmio_pkg::DATA_O_LO: rd_mux = out_data[31:0];
            mmio_pkg::DATA_O_HI: rd_mux = out_data[63:32];
            default:             rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            soft_rst_n <= 1'b0;
            last       <= 1'b0;
            mode       <= 2'b00;
            stage_lo   <= '0;
            stage_hi   <= '0;
        end else if (wr_en_i) begin
            case (wr_idx)
                mmio_pkg::CTRL_0: soft_rst_n <= wr_data_i[mmio_pkg::ctrl0_rst_bit];
                mmio_pkg::CTRL_1: begin
                    last <= wr_data_i[mmio_pkg::ctrl1_last_bit];
                    mode <= wr_data_i[mmio_pkg::ctrl1_mode_lsb +: 2];
                end
                mmio_pkg::DATA_I_LO: stage_lo <= wr_data_i;
                mmio_pkg::DATA_I_HI: stage_hi <= wr_data_i;
                default: ;
            endcase
        end
    end

    // the HI write completes a word, it is held here until the core takes it
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_valid <= 1'b0;
            in_data  <= '0;
        end else if (wr_en_i && wr_idx == mmio_pkg::DATA_I_HI) begin
            in_valid <= 1'b1;
            in_data  <= {wr_data_i, stage_lo};
        end else if (in_ready) begin
            in_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
            out_ready <= 1'b0;
            next_d    <= 1'b0;
            done_d    <= 1'b0;
            intr_next <= 1'b0;
            intr_done <= 1'b0;
        end else begin
            if (rd_en_i) begin
                rd_data_o <= rd_mux;
            end
            out_ready <= out_valid & rd_en_i & (rd_idx == mmio_pkg::DATA_O_HI);
            next_d    <= core_next;
            done_d    <= core_done;
            if (core_next && !next_d) begin
                intr_next <= 1'b1; // new edge beats the clearing read
            end else if (ctrl0_rd) begin
                intr_next <= 1'b0;
            end
            if (core_done && !done_d) begin
                intr_done <= 1'b1;
            end else if (ctrl0_rd) begin
                intr_done <= 1'b0;
            end
        end
    end

    sha2 i_sha2 (
        .clk_i       (clk_i),
        .rst_n_i     (core_rst_n),
        .mode_i      (core_mode),
        .last_i      (last),
        .in_data_i   (in_data),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .next_o      (core_next),
        .done_o      (core_done)
    );

endmodule

`default_nettype wire

/* testbench/tb_sha2_model.svh */
// include inside the testbench module only; messages up to 183 bytes, i.e. three padded blocks
`ifndef TB_SHA2_MODEL_SVH
`define TB_SHA2_MODEL_SVH

logic [7:0]  msg_bytes [0:191];
logic [31:0] pad_words [0:47];  // big-endian message words after padding
logic [31:0] model_h   [0:7];

function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    rotr = (x >> n) | (x << (32 - n));
endfunction

// appends 0x80, zeros and the 64-bit bit length; returns the number of blocks
function automatic int pad_message(input int len);
    int          nblk;
    int          total;
    logic [7:0]  b;
    logic [63:0] bit_len;
    nblk    = (len + 9 + 63) / 64;
    total   = nblk * 64;
    bit_len = 64'(len) << 3;
    for (int i = 0; i < total; i++) begin
        if (i < len) begin
            b = msg_bytes[i];
        end else if (i == len) begin
            b = 8'h80;
        end else if (i >= total - 8) begin
            b = bit_len[8 * (total - 1 - i) +: 8];
        end else begin
            b = 8'h00;
        end
        pad_words[i >> 2] = {pad_words[i >> 2][23:0], b};
    end
    pad_message = nblk;
endfunction

function automatic void model_init(input sha2_pkg::sha2_mode_t mode);
    for (int i = 0; i < 8; i++) begin
        model_h[i] = (mode == sha2_pkg::SHA224) ? sha2_pkg::iv_224[i] : sha2_pkg::iv_256[i];
    end
endfunction

function automatic void compress_block(input int blk);
    logic [31:0] w [0:63];
    logic [31:0] a, b, c, d, e, f, g, h;
    logic [31:0] s0, s1, t1, t2;
    for (int t = 0; t < 16; t++) begin
        w[t] = pad_words[blk * 16 + t];
    end
    for (int t = 16; t < 64; t++) begin
        s0   = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    {a, b, c, d} = {model_h[0], model_h[1], model_h[2], model_h[3]};
    {e, f, g, h} = {model_h[4], model_h[5], model_h[6], model_h[7]};
    for (int t = 0; t < 64; t++) begin
        t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
           + sha2_pkg::round_k[t] + w[t];
        t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
        {h, g, f, e} = {g, f, e, d + t1};
        {d, c, b, a} = {c, b, a, t1 + t2};
    end
    model_h[0] += a;
    model_h[1] += b;
    model_h[2] += c;
    model_h[3] += d;
    model_h[4] += e;
    model_h[5] += f;
    model_h[6] += g;
    model_h[7] += h;
endfunction

`endif

/* testbench/tb_mmio_sha2.sv */
// random messages against a software SHA-224/256 model; a timeout on intr_o ends the run
`timescale 1ns/10ps
`default_nettype none

module tb_mmio_sha2;

    localparam int addr_width = 8;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  wr_en_i;
    logic [addr_width-1:0] wr_addr_i;
    logic [31:0]           wr_data_i;
    logic                  rd_en_i;
    logic [addr_width-1:0] rd_addr_i;
    logic [31:0]           rd_data_o;
    logic                  intr_o;

    int          seed = 49820;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    logic [31:0] rd;
    logic [63:0] got_digest [0:3];

    `include "tb_sha2_model.svh"

    mmio_sha2 #(.addr_width(addr_width)) i_mmio_sha2 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .intr_o    (intr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [addr_width-1:0] reg_addr(input mmio_pkg::reg_idx_t idx);
        reg_addr = addr_width'({idx, 2'b00});
    endfunction

    function automatic logic [31:0] ctrl1_value(input logic last, input logic [1:0] mode);
        ctrl1_value = '0;
        ctrl1_value[mmio_pkg::ctrl1_last_bit]      = last;
        ctrl1_value[mmio_pkg::ctrl1_mode_lsb +: 2] = mode;
    endfunction

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic bus_write(input mmio_pkg::reg_idx_t idx, input logic [31:0] data);
        @(posedge clk_i);
        wr_en_i   <= 1'b1;
        wr_addr_i <= reg_addr(idx);
        wr_data_i <= data;
        @(posedge clk_i);
        wr_en_i   <= 1'b0;
    endtask

    task automatic bus_read(input mmio_pkg::reg_idx_t idx, output logic [31:0] data);
        @(posedge clk_i);
        rd_en_i   <= 1'b1;
        rd_addr_i <= reg_addr(idx);
        @(posedge clk_i);
        rd_en_i   <= 1'b0;
        @(posedge clk_i); // rd_data_o settled one cycle after the strobe
        data = rd_data_o;
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_intr(input logic exp);
        if (intr_o !== exp) begin
            $display("** Error at %0t: intr_o expected %b, got %b", $time, exp, intr_o);
            err_cnt++;
        end
    endtask

    task automatic check_digest(input sha2_pkg::sha2_mode_t mode);
        logic [63:0] exp;
        for (int k = 0; k < 4; k++) begin
            exp = {model_h[2*k], model_h[2*k+1]};
            if (mode == sha2_pkg::SHA224 && k == 3) exp[31:0] = 32'h0; // H7 not part of SHA-224
            if (got_digest[k] !== exp) begin
                $display("** Error at %0t: digest word %0d expected %h, got %h",
                         $time, k, exp, got_digest[k]);
                err_cnt++;
            end
        end
    endtask

    task automatic read_digest(input logic [31:0] ctrl1_exp);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] ctrl1;
        for (int k = 0; k < 4; k++) begin
            bus_read(mmio_pkg::DATA_O_LO, lo);
            bus_read(mmio_pkg::CTRL_1, ctrl1);
            check_reg("CTRL_1", ctrl1_exp, ctrl1); // done holds up to the fourth HI read
            bus_read(mmio_pkg::DATA_O_HI, hi); // advances to the next word
            got_digest[k] = {hi, lo};
        end
    endtask

    task automatic wait_intr(input string what);
        int cycles;
        cycles = 0;
        while (intr_o !== 1'b1 && cycles < 200) begin
            @(posedge clk_i);
            cycles++;
        end
        if (intr_o !== 1'b1) begin
            $display("timeout at %0t: intr_o never rose while waiting for %s", $time, what);
            timeout_cnt++;
            finish_run();
        end
    endtask

    task automatic send_block(input int blk);
        for (int i = 0; i < 8; i++) begin
            bus_write(mmio_pkg::DATA_I_LO, pad_words[blk*16 + 2*i + 1]);
            bus_write(mmio_pkg::DATA_I_HI, pad_words[blk*16 + 2*i]);
        end
    endtask

    task automatic hash_message(input logic [1:0] mode, input int len);
        sha2_pkg::sha2_mode_t m;
        int                   nblk;
        logic [31:0]          exp0;
        m = (mode == 2'b00) ? sha2_pkg::SHA224 : sha2_pkg::SHA256;
        for (int i = 0; i < len; i++) begin
            msg_bytes[i] = 8'($random(seed));
        end
        nblk = pad_message(len);
        model_init(m);
        for (int b = 0; b < nblk; b++) begin
            compress_block(b);
        end
        for (int b = 0; b < nblk; b++) begin
            bus_write(mmio_pkg::CTRL_1, ctrl1_value(b == nblk - 1, mode));
            send_block(b);
            wait_intr((b == nblk - 1) ? "digest done" : "next block");
            exp0 = 32'd1 << mmio_pkg::ctrl0_rst_bit;
            exp0 |= 32'd1 << ((b == nblk - 1) ? mmio_pkg::ctrl0_intr_done_bit
                                               : mmio_pkg::ctrl0_intr_next_bit);
            bus_read(mmio_pkg::CTRL_0, rd);
            check_reg("CTRL_0", exp0, rd);
            check_intr(1'b0);
        end
        read_digest(ctrl1_value(1'b1, mode) | (32'd1 << mmio_pkg::ctrl1_done_bit));
        check_digest(m);
        bus_read(mmio_pkg::CTRL_1, rd);
        check_reg("CTRL_1", ctrl1_value(1'b1, mode), rd); // done gone after the last word
    endtask

    initial begin
        rst_n_i   = 1'b0;
        wr_en_i   = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_en_i   = 1'b0;
        rd_addr_i = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        bus_read(mmio_pkg::CTRL_0, rd);
        check_reg("CTRL_0", 32'h0, rd);
        bus_read(mmio_pkg::CTRL_1, rd);
        check_reg("CTRL_1", 32'h0, rd);
        bus_read(mmio_pkg::RSVD_0, rd);
        check_reg("RSVD_0", 32'h0, rd);
        bus_read(mmio_pkg::RSVD_1, rd);
        check_reg("RSVD_1", 32'h0, rd);
        check_intr(1'b0);
        bus_write(mmio_pkg::CTRL_0, 32'h1);

        for (int n = 0; n < 4; n++) begin
            hash_message(2'b01, $unsigned($random(seed)) % 56); // fits one block
        end
        for (int n = 0; n < 4; n++) begin
            hash_message(2'b00, 56 + $unsigned($random(seed)) % 95);
        end

        // partial block followed by a core reset through CTRL_0
        bus_write(mmio_pkg::CTRL_1, ctrl1_value(1'b1, 2'b01));
        for (int i = 0; i < 3; i++) begin
            bus_write(mmio_pkg::DATA_I_LO, $random(seed));
            bus_write(mmio_pkg::DATA_I_HI, $random(seed));
        end
        bus_write(mmio_pkg::CTRL_0, 32'h0);
        bus_read(mmio_pkg::CTRL_0, rd);
        check_reg("CTRL_0", 32'h0, rd);
        bus_write(mmio_pkg::CTRL_0, 32'h1);
        hash_message(2'b01, $unsigned($random(seed)) % 151);

        for (int n = 0; n < 6; n++) begin
            hash_message((n % 2) ? 2'(1 + $unsigned($random(seed)) % 3) : 2'b00,
                         $unsigned($random(seed)) % 151);
        end

        finish_run();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+testbench
verilog/sha2_pkg.sv
verilog/mmio_pkg.sv
verilog/sha2_msg_sched.sv
verilog/sha2_round.sv
verilog/sha2_digest.sv
verilog/sha2.sv
verilog/mmio_sha2.sv
testbench/tb_mmio_sha2.sv
